// ==== src/ram_pkg.sv ====
package ram_pkg;

   // ********************************************************************
   // Memory geometry
   // ********************************************************************
   localparam int RAM_DEPTH  = 2048;               // Words in the buffer
   localparam int ADDR_W     = 11;                 // Word address bits
   localparam int DATA_W     = 16;                 // Stream word bits

   // Read and write pointers carry one wrap bit above the address
   localparam int PTR_W      = ADDR_W + 1;

   // Holds any count from 0 up to RAM_DEPTH
   localparam int CREDIT_W   = 12;

   // ********************************************************************
   // Block-RAM slices
   // ********************************************************************
   localparam int SLICE_W    = 2;                  // Bits per slice
   localparam int SLICE_MODE = 3;                  // iCE40 mode for 2048x2

endpackage

// ==== src/ice_ram_dxwb.sv ====
module ice_ram_dxwb #(
   parameter int pD    = 2048,
   parameter int pW    = 2,
   parameter int pMODE = 3
) (
   input  logic                   i_wclk,
   input  logic [$clog2(pD)-1:0]  i_waddr,
   input  logic                   i_we,
   input  logic [pW-1:0]          i_wdata,
   input  logic                   i_rclk,
   input  logic [$clog2(pD)-1:0]  i_raddr,
   input  logic                   i_re,
   output logic [pW-1:0]          o_rdata
);

   logic [pW-1:0] mem [pD];

   // iCE40 4K block modes: 0 = 256x16, 1 = 512x8, 2 = 1024x4, 3 = 2048x2
   if ((pMODE < 0) || (pMODE > 3)) begin : g_mode_range
      $error("ice_ram_dxwb: pMODE %0d is not an iCE40 RAM mode", pMODE);
   end else if ((pW != (16 >> pMODE)) || (pD != (256 << pMODE))) begin : g_mode_shape
      $error("ice_ram_dxwb: pMODE %0d does not match %0dx%0d", pMODE, pD, pW);
   end

   always_ff @(posedge i_wclk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   // Registered read port, holds its value when idle
   always_ff @(posedge i_rclk) begin
      if (i_re) begin
         o_rdata <= mem[i_raddr];
      end
   end

endmodule

// ==== src/ice_ram_2048x16b.sv ====
module ice_ram_2048x16b (
   input  logic                          i_wclk,
   input  logic [ram_pkg::ADDR_W-1:0]    i_waddr,
   input  logic                          i_we,
   input  logic [ram_pkg::DATA_W-1:0]    i_wdata,
   input  logic                          i_rclk,
   input  logic [ram_pkg::ADDR_W-1:0]    i_raddr,
   input  logic                          i_re,
   output logic [ram_pkg::DATA_W-1:0]    o_rdata
);

   logic [ram_pkg::SLICE_W-1:0] rdata7;
   logic [ram_pkg::SLICE_W-1:0] rdata6;
   logic [ram_pkg::SLICE_W-1:0] rdata5;
   logic [ram_pkg::SLICE_W-1:0] rdata4;
   logic [ram_pkg::SLICE_W-1:0] rdata3;
   logic [ram_pkg::SLICE_W-1:0] rdata2;
   logic [ram_pkg::SLICE_W-1:0] rdata1;
   logic [ram_pkg::SLICE_W-1:0] rdata0;

   // Most significant slice first
   assign o_rdata = {rdata7, rdata6, rdata5, rdata4, rdata3, rdata2, rdata1, rdata0};

   // ********************************************************************
   // Upper byte slices
   // ********************************************************************
   ice_ram_dxwb #(
      .pD      (ram_pkg::RAM_DEPTH),
      .pW      (ram_pkg::SLICE_W),
      .pMODE   (ram_pkg::SLICE_MODE)
   ) ram7 (
      .i_wclk  (i_wclk),
      .i_waddr (i_waddr),
      .i_we    (i_we),
      .i_wdata (i_wdata[7*ram_pkg::SLICE_W +: ram_pkg::SLICE_W]),   // Bits 15:14
      .i_rclk  (i_rclk),
      .i_raddr (i_raddr),
      .i_re    (i_re),
      .o_rdata (rdata7)
   );

   ice_ram_dxwb #(
      .pD      (ram_pkg::RAM_DEPTH),
      .pW      (ram_pkg::SLICE_W),
      .pMODE   (ram_pkg::SLICE_MODE)
   ) ram6 (
      .i_wclk  (i_wclk),
      .i_waddr (i_waddr),
      .i_we    (i_we),
      .i_wdata (i_wdata[6*ram_pkg::SLICE_W +: ram_pkg::SLICE_W]),
      .i_rclk  (i_rclk),
      .i_raddr (i_raddr),
      .i_re    (i_re),
      .o_rdata (rdata6)
   );

   ice_ram_dxwb #(
      .pD      (ram_pkg::RAM_DEPTH),
      .pW      (ram_pkg::SLICE_W),
      .pMODE   (ram_pkg::SLICE_MODE)
   ) ram5 (
      .i_wclk  (i_wclk),
      .i_waddr (i_waddr),
      .i_we    (i_we),
      .i_wdata (i_wdata[5*ram_pkg::SLICE_W +: ram_pkg::SLICE_W]),
      .i_rclk  (i_rclk),
      .i_raddr (i_raddr),
      .i_re    (i_re),
      .o_rdata (rdata5)
   );

   ice_ram_dxwb #(
      .pD      (ram_pkg::RAM_DEPTH),
      .pW      (ram_pkg::SLICE_W),
      .pMODE   (ram_pkg::SLICE_MODE)
   ) ram4 (
      .i_wclk  (i_wclk),
      .i_waddr (i_waddr),
      .i_we    (i_we),
      .i_wdata (i_wdata[4*ram_pkg::SLICE_W +: ram_pkg::SLICE_W]),
      .i_rclk  (i_rclk),
      .i_raddr (i_raddr),
      .i_re    (i_re),
      .o_rdata (rdata4)
   );

   // ********************************************************************
   // Lower byte slices
   // ********************************************************************
   ice_ram_dxwb #(
      .pD      (ram_pkg::RAM_DEPTH),
      .pW      (ram_pkg::SLICE_W),
      .pMODE   (ram_pkg::SLICE_MODE)
   ) ram3 (
      .i_wclk  (i_wclk),
      .i_waddr (i_waddr),
      .i_we    (i_we),
      .i_wdata (i_wdata[3*ram_pkg::SLICE_W +: ram_pkg::SLICE_W]),
      .i_rclk  (i_rclk),
      .i_raddr (i_raddr),
      .i_re    (i_re),
      .o_rdata (rdata3)
   );

   ice_ram_dxwb #(
      .pD      (ram_pkg::RAM_DEPTH),
      .pW      (ram_pkg::SLICE_W),
      .pMODE   (ram_pkg::SLICE_MODE)
   ) ram2 (
      .i_wclk  (i_wclk),
      .i_waddr (i_waddr),
      .i_we    (i_we),
      .i_wdata (i_wdata[2*ram_pkg::SLICE_W +: ram_pkg::SLICE_W]),
      .i_rclk  (i_rclk),
      .i_raddr (i_raddr),
      .i_re    (i_re),
      .o_rdata (rdata2)
   );

   ice_ram_dxwb #(
      .pD      (ram_pkg::RAM_DEPTH),
      .pW      (ram_pkg::SLICE_W),
      .pMODE   (ram_pkg::SLICE_MODE)
   ) ram1 (
      .i_wclk  (i_wclk),
      .i_waddr (i_waddr),
      .i_we    (i_we),
      .i_wdata (i_wdata[1*ram_pkg::SLICE_W +: ram_pkg::SLICE_W]),
      .i_rclk  (i_rclk),
      .i_raddr (i_raddr),
      .i_re    (i_re),
      .o_rdata (rdata1)
   );

   ice_ram_dxwb #(
      .pD      (ram_pkg::RAM_DEPTH),
      .pW      (ram_pkg::SLICE_W),
      .pMODE   (ram_pkg::SLICE_MODE)
   ) ram0 (
      .i_wclk  (i_wclk),
      .i_waddr (i_waddr),
      .i_we    (i_we),
      .i_wdata (i_wdata[0 +: ram_pkg::SLICE_W]),                    // Bits 1:0
      .i_rclk  (i_rclk),
      .i_raddr (i_raddr),
      .i_re    (i_re),
      .o_rdata (rdata0)
   );

endmodule

// ==== src/credit_rx.sv ====
module credit_rx #(
   parameter int P_IN_CREDITS = 2048
) (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_in_valid,
   input  logic [ram_pkg::DATA_W-1:0]    i_in_data,
   input  logic                          i_pop,
   output logic                          o_in_credit,
   output logic                          o_we,
   output logic [ram_pkg::ADDR_W-1:0]    o_waddr,
   output logic [ram_pkg::DATA_W-1:0]    o_wdata,
   output logic [ram_pkg::PTR_W-1:0]     o_wr_ptr,
   output logic                          o_err_overrun
);

   logic [ram_pkg::CREDIT_W-1:0] credit_cnt;       // Credits held upstream
   logic [ram_pkg::PTR_W-1:0]    wr_ptr;
   logic                         accept;

   if ((P_IN_CREDITS < 1) || (P_IN_CREDITS > ram_pkg::RAM_DEPTH)) begin : g_credit_range
      $error("credit_rx: P_IN_CREDITS %0d outside 1..%0d", P_IN_CREDITS, ram_pkg::RAM_DEPTH);
   end

   assign accept      = i_in_valid && (credit_cnt != '0);
   assign o_we        = accept;                     // Written at the accept edge
   assign o_waddr     = wr_ptr[ram_pkg::ADDR_W-1:0];
   assign o_wdata     = i_in_data;
   assign o_wr_ptr    = wr_ptr;
   assign o_in_credit = i_pop;                      // Each word out frees one slot

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         credit_cnt    <= ram_pkg::CREDIT_W'(P_IN_CREDITS);
         wr_ptr        <= '0;
         o_err_overrun <= 1'b0;
      end else begin
         if (accept) begin
            wr_ptr <= wr_ptr + 1'b1;
         end

         // Spend on accept, regain on pop, both together cancel
         if (accept && !i_pop) begin
            credit_cnt <= credit_cnt - 1'b1;
         end else if (!accept && i_pop) begin
            credit_cnt <= credit_cnt + 1'b1;
         end

         if (i_in_valid && !accept) begin
            o_err_overrun <= 1'b1;                  // Sticky until reset
         end
      end
   end

endmodule

// ==== src/stream_rd_ctrl.sv ====
module stream_rd_ctrl (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic [ram_pkg::PTR_W-1:0]     i_wr_ptr,
   input  logic                          i_out_credit,
   input  logic [ram_pkg::DATA_W-1:0]    i_rdata,
   output logic                          o_re,
   output logic [ram_pkg::ADDR_W-1:0]    o_raddr,
   output logic                          o_pop,
   output logic                          o_out_valid,
   output logic [ram_pkg::DATA_W-1:0]    o_out_data
);

   logic [ram_pkg::CREDIT_W-1:0] credit_cnt;       // Credits from downstream
   logic [ram_pkg::PTR_W-1:0]    rd_ptr;
   logic                         empty;
   logic                         has_credit;
   logic                         rd_issued;         // Read launched last cycle

   // ********************************************************************
   // Read issue
   // ********************************************************************
   assign empty      = (rd_ptr == i_wr_ptr);        // Wrap bits equal too
   assign has_credit = (credit_cnt != '0);
   assign o_re       = !empty && has_credit;
   assign o_raddr    = rd_ptr[ram_pkg::ADDR_W-1:0];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rd_ptr <= '0;
      end else if (o_re) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Downstream credit may arrive in the same cycle one is spent
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         credit_cnt <= '0;
      end else begin
         if (i_out_credit && !o_re) begin
            credit_cnt <= credit_cnt + 1'b1;
         end else if (!i_out_credit && o_re) begin
            credit_cnt <= credit_cnt - 1'b1;
         end
      end
   end

   // ********************************************************************
   // Output stage
   // ********************************************************************
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rd_issued <= 1'b0;
      end else begin
         rd_issued <= o_re;
      end
   end

   // RAM output register already holds the word for this cycle
   assign o_out_valid = rd_issued;
   assign o_pop       = rd_issued;
   assign o_out_data  = i_rdata;

endmodule

// ==== src/stream_buffer_top.sv ====
module stream_buffer_top #(
   parameter int P_IN_CREDITS = 2048
) (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_in_valid,
   input  logic [ram_pkg::DATA_W-1:0]    i_in_data,
   output logic                          o_in_credit,
   input  logic                          i_out_credit,
   output logic                          o_out_valid,
   output logic [ram_pkg::DATA_W-1:0]    o_out_data,
   output logic                          o_err_overrun
);

   logic                          we;
   logic [ram_pkg::ADDR_W-1:0]    waddr;
   logic [ram_pkg::DATA_W-1:0]    wdata;
   logic [ram_pkg::PTR_W-1:0]     wr_ptr;
   logic                          re;
   logic [ram_pkg::ADDR_W-1:0]    raddr;
   logic [ram_pkg::DATA_W-1:0]    rdata;
   logic                          pop;

   // ********************************************************************
   // Upstream side
   // ********************************************************************
   credit_rx #(
      .P_IN_CREDITS  (P_IN_CREDITS)
   ) u_credit_rx (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_in_valid    (i_in_valid),
      .i_in_data     (i_in_data),
      .i_pop         (pop),
      .o_in_credit   (o_in_credit),
      .o_we          (we),
      .o_waddr       (waddr),
      .o_wdata       (wdata),
      .o_wr_ptr      (wr_ptr),
      .o_err_overrun (o_err_overrun)
   );

   // ********************************************************************
   // Storage
   // ********************************************************************
   ice_ram_2048x16b u_ram (
      .i_wclk        (i_clk),                   // Single clock domain
      .i_waddr       (waddr),
      .i_we          (we),
      .i_wdata       (wdata),
      .i_rclk        (i_clk),
      .i_raddr       (raddr),
      .i_re          (re),
      .o_rdata       (rdata)
   );

   // ********************************************************************
   // Downstream side
   // ********************************************************************
   stream_rd_ctrl u_rd_ctrl (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_wr_ptr      (wr_ptr),
      .i_out_credit  (i_out_credit),
      .i_rdata       (rdata),
      .o_re          (re),
      .o_raddr       (raddr),
      .o_pop         (pop),                     // Returns an upstream credit
      .o_out_valid   (o_out_valid),
      .o_out_data    (o_out_data)
   );

endmodule

// ==== tb/stream_buffer_asserts.sv ====
module stream_buffer_asserts (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_out_valid,
   input  logic                          i_out_credit,
   input  logic [ram_pkg::CREDIT_W-1:0]  i_credit_cnt,
   input  logic [ram_pkg::PTR_W-1:0]     i_rd_ptr,
   input  logic [ram_pkg::PTR_W-1:0]     i_wr_ptr
);

   int                        fail_cnt = 0;          // Failed assertions so far
   logic [ram_pkg::PTR_W-1:0] fill;                  // Words held in the RAM

   assign fill = i_wr_ptr - i_rd_ptr;

   // Each output word spent a credit on the read one cycle earlier
   a_valid_has_credit : assert property (@(posedge i_clk) disable iff (i_rst)
      i_out_valid |-> (($past(i_credit_cnt) != '0) &&
                       (i_credit_cnt == $past(i_credit_cnt) + $past(i_out_credit) - 1'b1)))
      else begin
         fail_cnt++;
         $error("o_out_valid high without a credit spent in the previous cycle");
      end

   // A read on an empty buffer pushes the fill count past the depth
   a_no_read_empty : assert property (@(posedge i_clk) disable iff (i_rst)
      fill <= ram_pkg::RAM_DEPTH)
      else begin
         fail_cnt++;
         $error("Read pointer ran past the write pointer");
      end

   // ********************************************************************
   // Credit counter bounds
   // ********************************************************************
   a_credit_no_underflow : assert property (@(posedge i_clk) disable iff (i_rst)
      (i_credit_cnt == '0) |=> !(&i_credit_cnt))
      else begin
         fail_cnt++;
         $error("Downstream credit count wrapped below zero");
      end

   a_credit_no_overflow : assert property (@(posedge i_clk) disable iff (i_rst)
      (&i_credit_cnt) |=> (i_credit_cnt != '0))
      else begin
         fail_cnt++;
         $error("Downstream credit count wrapped above its maximum");
      end

endmodule

bind stream_rd_ctrl stream_buffer_asserts u_asserts (
   .i_clk        (i_clk),
   .i_rst        (i_rst),
   .i_out_valid  (o_out_valid),
   .i_out_credit (i_out_credit),
   .i_credit_cnt (credit_cnt),
   .i_rd_ptr     (rd_ptr),
   .i_wr_ptr     (i_wr_ptr)
);

// ==== tb/stream_buffer_tb.sv ====
module stream_buffer_tb;

   localparam int IN_CREDITS  = 2048;
   localparam int BURST_WORDS = 200;
   localparam int WRAP_WORDS  = 2500;
   // Words across all tests, at most about four cycles each
   localparam int TOTAL_WORDS = 4 + 1 + BURST_WORDS + 2 * IN_CREDITS + WRAP_WORDS;
   localparam int MAX_CYCLES  = 4 * TOTAL_WORDS + 1000;

   logic                       i_clk;
   logic                       i_rst;
   logic                       i_in_valid;
   logic [ram_pkg::DATA_W-1:0] i_in_data;
   logic                       o_in_credit;
   logic                       i_out_credit;
   logic                       o_out_valid;
   logic [ram_pkg::DATA_W-1:0] o_out_data;
   logic                       o_err_overrun;

   logic [ram_pkg::DATA_W-1:0] sent_q [$];          // Accepted words, oldest first
   logic [31:0]                lcg_state;
   int up_credits;
   int credit_pending;
   int down_held;                                   // Downstream credits not yet used
   int out_cnt;
   int in_credit_cnt;
   int cycle_cnt;
   int err_cnt;
   int tests_run;
   int tests_failed;

   stream_buffer_top dut0 (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_in_valid    (i_in_valid),
      .i_in_data     (i_in_data),
      .o_in_credit   (o_in_credit),
      .i_out_credit  (i_out_credit),
      .o_out_valid   (o_out_valid),
      .o_out_data    (o_out_data),
      .o_err_overrun (o_err_overrun)
   );

   initial i_clk = 1'b0;
   always #20 i_clk = ~i_clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // ********************************************************************
   // Cycle, drive and check helpers
   // ********************************************************************
   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
         err_cnt++;
      end
   endtask

   task automatic check_count(input string name, input int actual, input int expected);
      if (actual != expected) begin
         $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
         err_cnt++;
      end
   endtask

   task automatic tick();
      logic [ram_pkg::DATA_W-1:0] expected;
      @(posedge i_clk);
      #1;
      up_credits     += credit_pending;             // Usable from the next cycle
      credit_pending  = 0;
      check_bit("o_in_credit", o_in_credit, o_out_valid);
      if (o_in_credit === 1'b1) begin
         credit_pending = 1;
         in_credit_cnt++;
      end
      if (o_out_valid === 1'b1) begin
         out_cnt++;
         if (down_held == 0) begin
            $display("Output word at %0t came without a downstream credit", $time);
            err_cnt++;
         end else begin
            down_held--;
         end
         if (sent_q.size() == 0) begin
            $display("Output word %h at %0t came with no word outstanding", o_out_data, $time);
            err_cnt++;
         end else begin
            expected = sent_q.pop_front();
            if (o_out_data !== expected) begin
               $display("** Error at %0t: o_out_data = %h, expected %h",
                        $time, o_out_data, expected);
               err_cnt++;
            end
         end
      end
   endtask

   task automatic drive_cycle(input logic send, input logic [ram_pkg::DATA_W-1:0] data,
                              input logic credit);
      i_in_valid   = send;
      i_in_data    = data;
      i_out_credit = credit;
      if (send && (up_credits > 0)) begin
         sent_q.push_back(data);
         up_credits--;
      end
      if (credit) begin
         down_held++;
      end
      tick();
      i_in_valid   = 1'b0;
      i_out_credit = 1'b0;
   endtask

   task automatic drain();
      while (sent_q.size() > 0) begin
         drive_cycle(1'b0, '0, down_held < sent_q.size());
      end
      repeat (2) tick();                             // Let the last credits return
   endtask

   task automatic fill_upstream();
      logic [31:0] r;
      while (up_credits > 0) begin
         r = next_rand();
         drive_cycle(1'b1, r[31:16], 1'b0);
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      tests_run++;
      if (err_cnt == err_start) begin
         $display("%-16s ok", name);
      end else begin
         tests_failed++;
         $display("%-16s FAILED, %0d errors", name, err_cnt - err_start);
      end
   endtask

   // ********************************************************************
   // Tests
   // ********************************************************************
   task automatic test_reset_state();
      int          err_start;
      logic [31:0] r;
      err_start = err_cnt;
      check_bit("o_out_valid", o_out_valid, 1'b0);
      check_bit("o_in_credit", o_in_credit, 1'b0);
      check_bit("o_err_overrun", o_err_overrun, 1'b0);
      for (int i = 0; i < 4; i++) begin
         r = next_rand();
         drive_cycle(1'b1, r[31:16], 1'b0);
      end
      repeat (8) tick();
      check_count("output words", out_cnt, 0);
      drain();
      finish_test("reset_state", err_start);
   endtask

   task automatic test_single_word();
      int          err_start;
      int          out_start;
      logic [31:0] r;
      err_start = err_cnt;
      drive_cycle(1'b0, '0, 1'b1);
      tick();
      out_start = out_cnt;
      r = next_rand();
      drive_cycle(1'b1, r[31:16], 1'b0);              // Accept edge
      check_count("output words", out_cnt - out_start, 0);
      tick();
      check_bit("o_out_valid", o_out_valid, 1'b1);
      check_bit("o_in_credit", o_in_credit, 1'b1);
      check_count("output words", out_cnt - out_start, 1);
      repeat (2) tick();
      finish_test("single_word", err_start);
   endtask

   task automatic test_burst();
      int          err_start;
      int          out_start;
      int          credit_start;
      int          sent;
      int          given;
      logic [31:0] r;
      logic        send;
      logic        credit;
      err_start    = err_cnt;
      out_start    = out_cnt;
      credit_start = in_credit_cnt;
      sent         = 0;
      given        = 0;
      while (sent < BURST_WORDS) begin
         r      = next_rand();
         send   = r[20] && (up_credits > 0);          // Upper bits, low ones repeat fast
         credit = r[25] && (given < BURST_WORDS);
         drive_cycle(send, r[31:16], credit);
         sent  += send;
         given += credit;
      end
      drain();
      check_count("output words", out_cnt - out_start, BURST_WORDS);
      check_count("o_in_credit pulses", in_credit_cnt - credit_start, BURST_WORDS);
      finish_test("burst", err_start);
   endtask

   task automatic test_back_pressure();
      int err_start;
      int out_start;
      err_start = err_cnt;
      out_start = out_cnt;
      check_count("upstream credits", up_credits, IN_CREDITS);
      fill_upstream();
      repeat (8) tick();
      check_count("output words", out_cnt - out_start, 0);
      check_count("words held", sent_q.size(), IN_CREDITS);
      drain();
      check_count("output words", out_cnt - out_start, IN_CREDITS);
      finish_test("back_pressure", err_start);
   endtask

   task automatic test_overrun();
      int err_start;
      int out_start;
      err_start = err_cnt;
      out_start = out_cnt;
      check_bit("o_err_overrun", o_err_overrun, 1'b0);
      fill_upstream();
      drive_cycle(1'b1, 16'hdead, 1'b0);             // No credit left, dropped
      check_bit("o_err_overrun", o_err_overrun, 1'b1);
      drain();
      drive_cycle(1'b0, '0, 1'b1);                   // Spare credit finds the buffer empty
      repeat (6) tick();
      check_count("output words", out_cnt - out_start, IN_CREDITS);
      check_bit("o_err_overrun", o_err_overrun, 1'b1);
      finish_test("overrun", err_start);
   endtask

   task automatic test_wrap();
      int          err_start;
      int          out_start;
      int          sent;
      int          given;
      logic [31:0] r;
      logic        send;
      err_start = err_cnt;
      out_start = out_cnt;
      sent      = 0;
      given     = 0;
      while ((sent < WRAP_WORDS) || (sent_q.size() > 0)) begin
         r    = next_rand();
         send = (sent < WRAP_WORDS) && (up_credits > 0);
         drive_cycle(send, r[31:16], given < WRAP_WORDS);
         sent += send;
         given++;
      end
      repeat (2) tick();
      check_count("output words", out_cnt - out_start, WRAP_WORDS);
      check_bit("o_err_overrun", o_err_overrun, 1'b1);
      finish_test("address_wrap", err_start);
   endtask

   // ********************************************************************
   // Main sequence and timeout
   // ********************************************************************
   initial begin
      lcg_state      = 32'h51d0_d7e1;
      i_rst          = 1'b1;
      i_in_valid     = 1'b0;
      i_in_data      = '0;
      i_out_credit   = 1'b0;
      up_credits     = IN_CREDITS;
      credit_pending = 0;
      down_held      = 0;
      out_cnt        = 0;
      in_credit_cnt  = 0;
      err_cnt        = 0;
      tests_run      = 0;
      tests_failed   = 0;
      repeat (2) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      test_reset_state();
      test_single_word();
      test_burst();
      test_back_pressure();
      test_overrun();
      test_wrap();
      err_cnt += dut0.u_rd_ctrl.u_asserts.fail_cnt;
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
   end

endmodule

// ==== flist.f ====
src/ram_pkg.sv
src/ice_ram_dxwb.sv
src/ice_ram_2048x16b.sv
src/credit_rx.sv
src/stream_rd_ctrl.sv
src/stream_buffer_top.sv
tb/stream_buffer_asserts.sv
tb/stream_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run; pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module stream_buffer_tb \
   -f flist.f -o sim_stream_buffer || { echo "Build failed"; exit 1; }

out=$(./obj_dir/sim_stream_buffer 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
